//--- filelist.f
hw/ppc_div_pkg.sv
hw/div_issue.sv
hw/div_core.sv
hw/div_result_fifo.sv
hw/div_writeback.sv
hw/div_unit.sv
verification/tb_div_unit.sv

//--- hw/div_core.sv
/* Radix-2 restoring divider. Produces one unsigned quotient bit per cycle from the
   operand magnitudes and returns the job with the quotient in place of the divisor. */
`default_nettype none

module div_core
    import ppc_div_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     arst_n,
    input  wire div_job_t job,
    input  wire logic     job_valid,
    output logic          job_ready,
    output div_job_t      done,
    output logic          done_valid,
    input  wire logic     done_ready
);

    div_state_e                 state_q;
    logic [$clog2(XLEN)-1:0]    step_q;        // Iteration counter.
    logic                       done_valid_q;
    div_job_t                   job_q;
    word_t                      rem_q;         // Partial remainder.
    word_t                      quot_q;        // Dividend bits shift out, quotient bits shift in.
    logic [0:XLEN]              shifted;
    logic [0:XLEN]              diff;

    assign job_ready  = (state_q == IDLE);
    assign done_valid = done_valid_q;

    // One restoring step: bring down the next dividend bit and try the subtraction.
    always_comb begin
        shifted = {rem_q, quot_q[0]};
        diff    = shifted - {1'b0, job_q.divisor};
    end

    always_comb begin
        done         = job_q;
        done.divisor = quot_q;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q      <= IDLE;
            step_q       <= '0;
            done_valid_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (job_valid) begin
                        state_q <= RUN;
                        step_q  <= '0;
                    end
                end
                RUN: begin
                    step_q <= step_q + 1'b1;
                    if (step_q == XLEN - 1) begin
                        state_q <= DONE;
                    end
                end
                DONE: begin
                    // The first DONE cycle raises valid, then we wait for the FIFO.
                    if (!done_valid_q) begin
                        done_valid_q <= 1'b1;
                    end else if (done_ready) begin
                        done_valid_q <= 1'b0;
                        state_q      <= IDLE;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && job_valid) begin
            job_q  <= job;
            rem_q  <= '0;
            quot_q <= job.dividend;
        end else if (state_q == RUN) begin
            if (!diff[0]) begin  // Non-negative, keep the difference.
                rem_q  <= diff[1:XLEN];
                quot_q <= {quot_q[1:XLEN-1], 1'b1};
            end else begin
                rem_q  <= shifted[1:XLEN];
                quot_q <= {quot_q[1:XLEN-1], 1'b0};
            end
        end
    end

    // A finished job is offered until the FIFO accepts it.
    assert property (@(posedge clk) disable iff (!arst_n)
        done_valid && !done_ready |=> done_valid && $stable(done));

endmodule

`default_nettype wire

//--- hw/div_issue.sv
/* Front stage of the divide unit. Registers one request, turns signed operands into
   magnitudes and flags the overflow cases before the divider sees the job. */
`default_nettype none

module div_issue
    import ppc_div_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     arst_n,
    input  wire div_req_t req,
    input  wire logic     req_valid,
    output logic          req_ready,
    output div_job_t      job,
    output logic          job_valid,
    input  wire logic     job_ready
);

    div_job_t next_job;
    logic     op1_neg;
    logic     op2_neg;
    logic     int_min_by_m1;

    // Only one job is held, so a new request waits until the divider takes it.
    assign req_ready = ~job_valid;

    always_comb begin
        op1_neg = req.ctrl.div_signed & req.op1[0];
        op2_neg = req.ctrl.div_signed & req.op2[0];

        // The one signed quotient that does not fit in 32 bits.
        int_min_by_m1 = req.ctrl.div_signed
                      && (req.op1 == {1'b1, {(XLEN - 1){1'b0}}})
                      && (req.op2 == '1);

        next_job.rs_id    = req.rs_id;
        next_job.dest     = req.dest;
        next_job.ctrl     = req.ctrl;
        next_job.dividend = op1_neg ? word_t'(-req.op1) : req.op1;
        next_job.divisor  = op2_neg ? word_t'(-req.op2) : req.op2;
        next_job.neg_quot = op1_neg ^ op2_neg;
        next_job.ovf      = (req.op2 == '0) || int_min_by_m1;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            job_valid <= 1'b0;
        end else if (req_valid && req_ready) begin
            job_valid <= 1'b1;
        end else if (job_ready) begin
            job_valid <= 1'b0;  // Handed to the divider.
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            job <= next_job;
        end
    end

    // The requester must keep its request steady until it is taken.
    assert property (@(posedge clk) disable iff (!arst_n)
        req_valid && !req_ready |=> req_valid && $stable(req));

endmodule

`default_nettype wire

//--- hw/div_result_fifo.sv
/* Ordered result buffer between the divider and writeback. Ready means not full, so the
   divider can drain while writeback is held off. */
`default_nettype none

module div_result_fifo
    import ppc_div_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     arst_n,
    input  wire div_job_t wr,
    input  wire logic     wr_valid,
    output logic          wr_ready,
    output div_job_t      rd,
    output logic          rd_valid,
    input  wire logic     rd_ready
);

    div_job_t                             mem [RES_FIFO_DEPTH];
    logic [$clog2(RES_FIFO_DEPTH)-1:0]    wr_ptr_q;
    logic [$clog2(RES_FIFO_DEPTH)-1:0]    rd_ptr_q;
    logic [$clog2(RES_FIFO_DEPTH):0]      count_q;
    logic                                 push;
    logic                                 pop;

    assign wr_ready = (count_q != RES_FIFO_DEPTH);
    assign rd_valid = (count_q != '0);
    assign rd       = mem[rd_ptr_q];  // Head entry, visible the cycle after its write.

    assign push = wr_valid && wr_ready;
    assign pop  = rd_valid && rd_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == RES_FIFO_DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == RES_FIFO_DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;  // Both or neither leave the fill level.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr_q] <= wr;
        end
    end

    // The pointers meet only when the FIFO is empty or full.
    // Any other meeting means a write went into an unread entry.
    assert property (@(posedge clk) disable iff (!arst_n)
        (wr_ptr_q == rd_ptr_q) == (count_q == '0 || count_q == RES_FIFO_DEPTH));

endmodule

`default_nettype wire

//--- hw/div_unit.sv
/* Top of the integer divide unit for divw and divwu. Chains issue, the iterative
   divider, the result FIFO and writeback with valid/ready links. */
`default_nettype none

module div_unit
    import ppc_div_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     arst_n,
    input  wire div_req_t req,
    input  wire logic     req_valid,
    output logic          req_ready,
    output div_res_t      res,
    output logic          res_valid,
    input  wire logic     res_ready
);

    div_job_t job;
    logic     job_valid;
    logic     job_ready;
    div_job_t done;
    logic     done_valid;
    logic     done_ready;
    div_job_t fifo_job;
    logic     fifo_valid;
    logic     fifo_ready;

    div_issue u_issue (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .job       (job),
        .job_valid (job_valid),
        .job_ready (job_ready)
    );

    div_core u_core (
        .clk        (clk),
        .arst_n     (arst_n),
        .job        (job),
        .job_valid  (job_valid),
        .job_ready  (job_ready),
        .done       (done),
        .done_valid (done_valid),
        .done_ready (done_ready)
    );

    // Finished jobs wait here while writeback is stalled.
    div_result_fifo u_fifo (
        .clk      (clk),
        .arst_n   (arst_n),
        .wr       (done),
        .wr_valid (done_valid),
        .wr_ready (done_ready),
        .rd       (fifo_job),
        .rd_valid (fifo_valid),
        .rd_ready (fifo_ready)
    );

    div_writeback u_writeback (
        .clk       (clk),
        .arst_n    (arst_n),
        .job       (fifo_job),
        .job_valid (fifo_valid),
        .job_ready (fifo_ready),
        .res       (res),
        .res_valid (res_valid),
        .res_ready (res_ready)
    );

endmodule

`default_nettype wire

//--- hw/div_writeback.sv
/* Final stage of the divide unit. Signs the quotient, builds the CR0 and XER bits,
   keeps the sticky summary overflow and holds the result until it is taken. */
`default_nettype none

module div_writeback
    import ppc_div_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     arst_n,
    input  wire div_job_t job,
    input  wire logic     job_valid,
    input  wire logic     res_ready,
    output logic          job_ready,
    output div_res_t      res,
    output logic          res_valid
);

    logic     so_q;      // Sticky summary overflow.
    logic     so_next;
    logic     load;
    word_t    quotient;
    div_res_t next_res;

    // The output register can take a new result when empty or being drained.
    assign job_ready = !res_valid || res_ready;
    assign load      = job_valid && job_ready;

    always_comb begin
        quotient = job.divisor;  // The divider put the quotient here.
        so_next  = so_q | (job.ctrl.alter_ov & job.ovf);

        next_res.rs_id  = job.rs_id;
        next_res.dest   = job.dest;
        next_res.result = job.ovf ? '0 : (job.neg_quot ? word_t'(-quotient) : quotient);

        next_res.flags.xer_ov = job.ctrl.alter_ov & job.ovf;
        next_res.flags.xer_so = so_next;

        // CR0 compares the signed result against zero.
        if (job.ctrl.alter_cr0) begin
            next_res.flags.cr0_lt = next_res.result[0];
            next_res.flags.cr0_gt = !next_res.result[0] && (next_res.result != '0);
            next_res.flags.cr0_eq = (next_res.result == '0);
            next_res.flags.cr0_so = so_next;
        end else begin
            next_res.flags.cr0_lt = 1'b0;
            next_res.flags.cr0_gt = 1'b0;
            next_res.flags.cr0_eq = 1'b0;
            next_res.flags.cr0_so = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_valid <= 1'b0;
            so_q      <= 1'b0;
        end else begin
            if (load) begin
                res_valid <= 1'b1;
                so_q      <= so_next;  // Only reset clears it again.
            end else if (res_ready) begin
                res_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            res <= next_res;
        end
    end

    // The FIFO head must stay put while this stage is stalled.
    assert property (@(posedge clk) disable iff (!arst_n)
        job_valid && !job_ready |=> job_valid && $stable(job));

endmodule

`default_nettype wire

//--- hw/ppc_div_pkg.sv
/* Shared widths, handshake payload structs and FSM encoding for the integer divide unit.
   Modules import this package in their headers. */
`default_nettype none

package ppc_div_pkg;

    localparam int XLEN           = 32;  // Operand and result width.
    localparam int RS_ID_W        = 5;   // Reservation-station tag width.
    localparam int REG_ADDR_W     = 5;   // Destination register address width.
    localparam int RES_FIFO_DEPTH = 4;   // Finished results that can wait for writeback.

    // PowerPC numbering, so bit 0 is the most significant bit.
    typedef logic [0:XLEN-1]       word_t;
    typedef logic [0:RS_ID_W-1]    rs_id_t;
    typedef logic [0:REG_ADDR_W-1] reg_addr_t;

    typedef struct packed {
        logic div_signed;  // Set for divw, clear for divwu.
        logic alter_cr0;   // Record form.
        logic alter_ov;    // OE form.
    } div_decode_t;

    typedef struct packed {
        rs_id_t      rs_id;
        reg_addr_t   dest;
        word_t       op1;  // Dividend.
        word_t       op2;  // Divisor.
        div_decode_t ctrl;
    } div_req_t;

    // Job as it travels from issue through the divider into the result FIFO.
    // After the divider the divisor field carries the unsigned quotient.
    typedef struct packed {
        rs_id_t      rs_id;
        reg_addr_t   dest;
        div_decode_t ctrl;
        word_t       dividend;
        word_t       divisor;
        logic        neg_quot;
        logic        ovf;
    } div_job_t;

    typedef struct packed {
        logic cr0_lt;
        logic cr0_gt;
        logic cr0_eq;
        logic cr0_so;
        logic xer_ov;
        logic xer_so;
    } cond_exception_t;

    typedef struct packed {
        rs_id_t          rs_id;
        reg_addr_t       dest;
        word_t           result;
        cond_exception_t flags;
    } div_res_t;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } div_state_e;

endpackage

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the divide unit testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f --top-module tb_div_unit > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed."; exit 1; }

./obj_dir/Vtb_div_unit > sim.log 2>&1
cat sim.log

grep -q "=== FAIL ===" sim.log && { echo "Simulation failed."; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "Simulation ended without a result."; exit 1; }
echo "Simulation passed."

//--- verification/tb_div_unit.sv
/* Random-stimulus testbench for the divide unit. It checks every result against a
   reference model under random request gaps and random res_ready back-pressure. */
`default_nettype none

module tb_div_unit
    import ppc_div_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          NUM_REQS       = 400;
    localparam int          TIMEOUT_CYCLES = NUM_REQS * 64 + 200;
    localparam int          DRAIN_CYCLES   = 64;  // Well past the unit's latency.
    localparam logic [31:0] LFSR_SEED      = 32'h607d88ca;

    logic     clk;
    logic     arst_n;
    div_req_t req;
    logic     req_valid;
    logic     req_ready;
    div_res_t res;
    logic     res_valid;
    logic     res_ready;

    logic [31:0] lfsr_q;       // Random source state.
    logic        model_so;     // Model copy of the sticky summary overflow.
    div_res_t    expected_q[$];

    div_unit dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .res       (res),
        .res_valid (res_valid),
        .res_ready (res_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1.
    function automatic logic lfsr_bit();
        logic fb;
        fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic logic [31:0] small_value();
        logic [31:0] v;
        v = random_bits(8);
        if (lfsr_bit()) begin
            v = -v;  // Small negative operand.
        end
        return v;
    endfunction

    function automatic div_req_t random_request();
        div_req_t r;
        int       kind;
        r.rs_id           = rs_id_t'(random_bits(RS_ID_W));
        r.dest            = reg_addr_t'(random_bits(REG_ADDR_W));
        r.ctrl.div_signed = lfsr_bit();
        r.ctrl.alter_cr0  = lfsr_bit();
        r.ctrl.alter_ov   = lfsr_bit();
        kind              = int'(random_bits(3));
        case (kind)
            0, 1: begin
                r.op1 = random_bits(32);
                r.op2 = random_bits(32);
            end
            2, 3: begin
                r.op1 = random_bits(32);
                r.op2 = small_value();
            end
            4, 5: begin
                r.op1 = small_value();
                r.op2 = small_value();
            end
            6: begin
                r.op1 = random_bits(32);
                r.op2 = '0;
            end
            default: begin
                r.op1 = 32'h8000_0000;  // Overflows only in signed mode.
                r.op2 = 32'hffff_ffff;
            end
        endcase
        return r;
    endfunction

    // Reference result built from the architectural rules, in issue order.
    function automatic div_res_t expected_result(input div_req_t r);
        div_res_t    e;
        logic [31:0] q;
        logic        ovf;
        int          a;
        int          b;
        a   = r.op1;
        b   = r.op2;
        ovf = (r.op2 == '0)
            || (r.ctrl.div_signed && r.op1 == 32'h8000_0000 && r.op2 == 32'hffff_ffff);
        if (ovf) begin
            q = '0;
        end else if (r.ctrl.div_signed) begin
            q = a / b;  // Signed division truncates toward zero.
        end else begin
            q = r.op1 / r.op2;
        end
        if (r.ctrl.alter_ov && ovf) begin
            model_so = 1'b1;
        end
        e.rs_id        = r.rs_id;
        e.dest         = r.dest;
        e.result       = q;
        e.flags.xer_ov = r.ctrl.alter_ov && ovf;
        e.flags.xer_so = model_so;
        e.flags.cr0_lt = r.ctrl.alter_cr0 && ($signed(q) < 0);
        e.flags.cr0_gt = r.ctrl.alter_cr0 && ($signed(q) > 0);
        e.flags.cr0_eq = r.ctrl.alter_cr0 && (q == '0);
        e.flags.cr0_so = r.ctrl.alter_cr0 && model_so;
        return e;
    endfunction

    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped after an error.");
    endtask

    task automatic check_res(input string name, input div_res_t got, input div_res_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flags(input string name, input cond_exception_t got,
                               input cond_exception_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    initial begin
        div_res_t exp_res;
        div_res_t held_res;
        logic     stalled;
        int       issued;
        int       received;
        int       cycle_count;
        int       ready_burst;

        lfsr_q      = LFSR_SEED;
        model_so    = 1'b0;
        arst_n      = 1'b0;
        req         = '0;
        req_valid   = 1'b0;
        res_ready   = 1'b0;
        held_res    = '0;
        stalled     = 1'b0;
        issued      = 0;
        received    = 0;
        cycle_count = 0;
        ready_burst = 0;

        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        if (res_valid !== 1'b0 || req_ready !== 1'b1) begin
            $display("After reset res_valid is not low or req_ready is not high.");
            abort_run();
        end

        while (received < NUM_REQS) begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count >= TIMEOUT_CYCLES) begin
                $display("Timeout: %0d of %0d results arrived within %0d cycles.",
                         received, NUM_REQS, cycle_count);
                abort_run();
            end

            // A stalled result must stay valid and unchanged.
            if (stalled) begin
                if (res_valid !== 1'b1) begin
                    $display("res_valid dropped while res_ready was low.");
                    abort_run();
                end
                check_res("res (held)", res, held_res);
            end
            stalled  = res_valid && !res_ready;
            held_res = res;

            if (res_valid && res_ready) begin
                if (expected_q.size() == 0) begin
                    $display("A result arrived with no request outstanding.");
                    abort_run();
                end
                exp_res = expected_q.pop_front();
                check_flags("res.flags", res.flags, exp_res.flags);
                check_res("res", res, exp_res);
                received++;
            end

            if (req_valid && req_ready) begin
                expected_q.push_back(expected_result(req));
                issued++;
                req_valid <= 1'b0;
            end

            // A waiting request is held, otherwise a new one may start.
            if (!(req_valid && !req_ready) && issued < NUM_REQS && random_bits(2) != 0) begin
                req       <= random_request();
                req_valid <= 1'b1;
            end

            if (ready_burst == 0) begin
                res_ready   <= (random_bits(2) != 0);
                ready_burst = 1 + int'(random_bits(4));
            end else begin
                ready_burst--;
            end
        end

        // Every request has its result, so nothing more may come out.
        repeat (DRAIN_CYCLES) begin
            @(posedge clk);
            if (res_valid !== 1'b0) begin
                $display("A result arrived after every request had been answered.");
                abort_run();
            end
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire
